// File: include/mem_checks.svh
`ifndef MEM_CHECKS_SVH
`define MEM_CHECKS_SVH

// ********************
// Result counters
// ********************
int error_count = 0;
int check_count = 0;

// Compares a returned line with the reference model.
task automatic check_line(
    input string          what,
    input mem_pkg::line_t got,
    input mem_pkg::line_t exp
);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
    end
endtask

// Compares a measured cycle count with the fixed one.
task automatic check_latency(
    input string what,
    input int    got,
    input int    exp
);
    check_count++;
    if (got != exp) begin
        error_count++;
        $display("[FAIL] %0t %s: got %0d cycles, expected %0d", $time, what, got, exp);
    end
endtask

`endif

// File: bench/mem_subsystem_tb.sv
`timescale 1ns/100ps

module mem_subsystem_tb;

    import mem_pkg::*;

    localparam int MEM_LINES    = 64;
    localparam int MEM_LATENCY  = 4;
    localparam int ROUNDS       = 12;
    localparam int NUM_ACCESSES = 16 + 2 + 2 + 3 + 8 + 2 * ROUNDS;

    `include "mem_checks.svh"

    logic     clk;
    logic     rst;
    mem_req_t i_req;
    mem_req_t d_req;
    mem_rsp_t i_rsp;
    mem_rsp_t d_rsp;
    line_t    model [MEM_LINES];    // Reference memory.
    int       seed = 32'h9498;

    mem_subsystem #(
        .MEM_LINES   (MEM_LINES),
        .MEM_LATENCY (MEM_LATENCY)
    ) mem_subsystem_inst (
        .clk   (clk),
        .rst   (rst),
        .i_req (i_req),
        .i_rsp (i_rsp),
        .d_req (d_req),
        .d_rsp (d_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (NUM_ACCESSES * (2 * MEM_LATENCY + 10) + 200) @(posedge clk);
        $display("Timeout: the directed tests did not finish in time.");
        $display("Regression failed");
        $finish;
    end

    function automatic line_t random_line();
        line_t r = '0;
        for (int k = 0; k < LINE_BITS / 32; k++) begin
            r = {r[LINE_BITS-33:0], $random(seed)};
        end
        return r;
    endfunction

    // ********************
    // Port access
    // ********************
    task automatic data_access(input logic wr, input int line, input line_t wdata,
                               output line_t rdata);
        mem_req_t req;
        req               = '0;
        req.read          = !wr;
        req.write         = wr;
        req.addr.line_num = LINE_NUM_BITS'(line);
        req.wdata         = wdata;
        @(posedge clk);
        d_req <= req;
        @(negedge clk);
        while (!d_rsp.resp) begin
            @(negedge clk);
        end
        rdata = d_rsp.rdata;
        @(posedge clk);
        d_req <= '0;
    endtask

    // Counts cycles from the read being raised to resp.
    task automatic instr_read(input int line, output line_t rdata, output int cycles);
        mem_req_t req;
        req               = '0;
        req.read          = 1'b1;
        req.addr.line_num = LINE_NUM_BITS'(line);
        req.addr.offset   = OFFSET_BITS'(line);
        @(posedge clk);
        i_req <= req;
        cycles = 0;
        @(negedge clk);
        while (!i_rsp.resp) begin
            cycles++;
            @(negedge clk);
        end
        rdata = i_rsp.rdata;
        @(posedge clk);
        i_req <= '0;
    endtask

    task automatic store_line(input int line, input line_t data);
        line_t unused;
        model[line] = data;
        data_access(1'b1, line, data, unused);
    endtask

    task automatic check_data_read(input int line);
        line_t got;
        data_access(1'b0, line, '0, got);
        check_line($sformatf("d_rsp.rdata of line %0d", line), got, model[line]);
    endtask

    task automatic check_instr_read(input int line);
        line_t got;
        int    cycles;
        instr_read(line, got, cycles);
        check_line($sformatf("i_rsp.rdata of line %0d", line), got, model[line]);
    endtask

    // ********************
    // Directed tests
    // ********************
    task automatic test_write_read();
        for (int n = 8; n < 16; n++) begin
            store_line(n, random_line());
        end
        for (int n = 8; n < 16; n++) begin
            check_data_read(n);
        end
    endtask

    task automatic test_prefetch_hit();
        line_t got;
        int    cycles;
        check_instr_read(10);
        repeat (MEM_LATENCY + 4) @(posedge clk);    // Gap, grant and latency of the next-line fill.
        instr_read(11, got, cycles);
        check_line("i_rsp.rdata of line 11", got, model[11]);
        check_latency("i_rsp.resp latency of line 11", cycles, 1);
    endtask

    // Line 11 is buffered here.
    task automatic test_snoop();
        store_line(11, random_line());
        check_instr_read(11);
    endtask

    task automatic test_nonseq();
        check_instr_read(14);
        check_instr_read(9);
        check_instr_read(3);
    endtask

    task automatic test_contention();
        line_t i_got;
        line_t d_got;
        line_t wdata;
        int    cycles;
        int    i_line;
        int    d_line;
        logic  wr;
        for (int n = 40; n < 48; n++) begin
            store_line(n, random_line());
        end
        for (int r = 0; r < ROUNDS; r++) begin
            i_line = 40 + r % 8;    // Sequential, so some reads wait on a fill.
            d_line = 16 + r % 8;
            wr     = ($random(seed) & 32'h1) != 0;
            wdata  = random_line();
            if (wr) begin
                model[d_line] = wdata;
            end
            fork
                instr_read(i_line, i_got, cycles);
                data_access(wr, d_line, wdata, d_got);
            join
            check_line($sformatf("i_rsp.rdata in round %0d", r), i_got, model[i_line]);
            if (!wr) begin
                check_line($sformatf("d_rsp.rdata in round %0d", r), d_got, model[d_line]);
            end
        end
    endtask

    initial begin
        rst   = 1'b1;
        i_req = '0;
        d_req = '0;
        for (int n = 0; n < MEM_LINES; n++) begin
            model[n] = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        test_write_read();
        test_prefetch_hit();
        test_snoop();
        test_nonseq();
        test_contention();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule : mem_subsystem_tb

// File: hw/line_memory.sv
`timescale 1ns/100ps

module line_memory #(
    parameter int MEM_LINES   = 64,
    parameter int MEM_LATENCY = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::mem_req_t req,
    output mem_pkg::mem_rsp_t rsp
);

    import mem_pkg::*;

    localparam int IDX_BITS = $clog2(MEM_LINES);
    localparam int CNT_BITS = $clog2(MEM_LATENCY + 1);

    line_t               lines [MEM_LINES];
    line_t               rdata_q;
    logic [IDX_BITS-1:0] idx;
    logic [CNT_BITS-1:0] cnt;
    logic                busy;
    logic                gap;       // Cycle after resp, request line ignored.
    logic                accept;

    assign idx    = req.addr.line_num[IDX_BITS-1:0];
    assign accept = !busy && !gap && (req.read || req.write);

    // ********************
    // Array and latency
    // ********************
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            gap  <= 1'b0;
            cnt  <= '0;
            for (int i = 0; i < MEM_LINES; i++) begin
                lines[i] <= '0;
            end
        end else begin
            gap <= rsp.resp;
            if (accept) begin
                busy <= 1'b1;
                cnt  <= CNT_BITS'(MEM_LATENCY - 1);
                if (req.write) begin
                    lines[idx] <= req.wdata;    // Stored at acceptance.
                end
            end else if (busy) begin
                if (cnt == '0) begin
                    busy <= 1'b0;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && req.read) begin
            rdata_q <= lines[idx];
        end
    end

    assign rsp.resp  = busy && (cnt == '0);
    assign rsp.rdata = rdata_q;

    assert property (@(posedge clk) disable iff (rst) !(req.read && req.write))
        else $error("Memory saw read and write together.");

endmodule : line_memory

// File: hw/line_prefetcher.sv
`timescale 1ns/100ps

module line_prefetcher (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::mem_req_t l1_req,
    output mem_pkg::mem_rsp_t l1_rsp,
    output mem_pkg::mem_req_t pf_req,
    input  mem_pkg::mem_rsp_t pf_rsp,
    input  mem_pkg::mem_req_t snoop
);

    import mem_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        HIT,
        PREFETCH
    } state_t;

    state_t state, next_state;

    logic                     buf_valid;
    logic [LINE_NUM_BITS-1:0] buf_line;
    line_t                    buf_data;
    logic [LINE_NUM_BITS-1:0] pf_line;     // Line being fetched in PREFETCH.
    logic                     pf_stale;
    logic                     hit_done;
    line_addr_t               next_addr;
    logic                     snoop_buf;
    logic                     snoop_pf;
    logic                     buf_hit;
    logic                     fill;

    assign next_addr = line_addr_t'(l1_req.addr + 32'(LINE_BYTES));
    assign snoop_buf = snoop.write && (snoop.addr.line_num == buf_line);
    assign snoop_pf  = snoop.write && (snoop.addr.line_num == pf_line);
    assign buf_hit   = buf_valid && !snoop_buf && (l1_req.addr.line_num == buf_line);
    assign fill      = (state == PREFETCH) && pf_rsp.resp;

    // ********************
    // Request steering
    // ********************
    always_comb begin
        pf_req       = '0;
        l1_rsp.resp  = 1'b0;
        l1_rsp.rdata = buf_data;
        next_state   = state;
        case (state)
            IDLE: begin
                // A read held over from a hit is not taken again.
                if (l1_req.read && !hit_done) begin
                    if (buf_hit) begin
                        next_state = HIT;
                    end else begin
                        pf_req       = l1_req;
                        pf_req.write = 1'b0;
                        l1_rsp.resp  = pf_rsp.resp;
                        l1_rsp.rdata = pf_rsp.rdata;
                        if (pf_rsp.resp) begin
                            next_state = PREFETCH;
                        end
                    end
                end
            end
            HIT: begin
                l1_rsp.resp = 1'b1;         // Served from the buffer.
                next_state  = IDLE;
            end
            PREFETCH: begin
                pf_req.read          = 1'b1;
                pf_req.addr.line_num = pf_line;
                if (pf_rsp.resp) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            buf_valid <= 1'b0;
            pf_stale  <= 1'b0;
            hit_done  <= 1'b0;
        end else begin
            state    <= next_state;
            hit_done <= (state == HIT);
            if (snoop_buf) begin
                buf_valid <= 1'b0;
            end
            if (fill) begin
                buf_valid <= !pf_stale && !snoop_pf;   // Drop a fill made stale by a write.
            end
            if (state == IDLE && next_state == PREFETCH) begin
                pf_stale <= 1'b0;
            end else if (state == PREFETCH && snoop_pf) begin
                pf_stale <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && next_state == PREFETCH) begin
            pf_line <= next_addr.line_num;
        end
        if (fill) begin
            buf_line <= pf_line;
            buf_data <= pf_rsp.rdata;
        end
    end

    assert property (@(posedge clk) disable iff (rst) l1_rsp.resp |-> l1_req.read)
        else $error("Instruction resp raised with no read pending.");

endmodule : line_prefetcher

// File: hw/mem_pkg.sv
package mem_pkg;

    // ********************
    // Geometry
    // ********************
    localparam int LINE_BYTES    = 32;              // Also the prefetch stride.
    localparam int ADDR_BITS     = 32;
    localparam int LINE_BITS     = LINE_BYTES * 8;
    localparam int OFFSET_BITS   = $clog2(LINE_BYTES);
    localparam int LINE_NUM_BITS = ADDR_BITS - OFFSET_BITS;

    // One full line of data.
    typedef logic [LINE_BITS-1:0] line_t;

    typedef struct packed {
        logic [LINE_NUM_BITS-1:0] line_num;
        logic [OFFSET_BITS-1:0]   offset;       // Byte within the line.
    } line_addr_t;

    // ********************
    // Port bundles
    // ********************

    // Held by the requester until resp pulses.
    typedef struct packed {
        logic       read;
        logic       write;
        line_addr_t addr;
        line_t      wdata;
    } mem_req_t;

    typedef struct packed {
        logic  resp;                            // One-cycle completion pulse.
        line_t rdata;
    } mem_rsp_t;

endpackage

// File: hw/mem_subsystem.sv
`timescale 1ns/100ps

module mem_subsystem #(
    parameter int MEM_LINES   = 64,
    parameter int MEM_LATENCY = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::mem_req_t i_req,
    output mem_pkg::mem_rsp_t i_rsp,
    input  mem_pkg::mem_req_t d_req,
    output mem_pkg::mem_rsp_t d_rsp
);

    import mem_pkg::*;

    mem_req_t pf_req;
    mem_rsp_t pf_rsp;
    mem_req_t mem_req;      // Also snooped by the prefetcher.
    mem_rsp_t mem_rsp;

    // ********************
    // Instruction side
    // ********************
    line_prefetcher line_prefetcher_inst (
        .clk    (clk),
        .rst    (rst),
        .l1_req (i_req),
        .l1_rsp (i_rsp),
        .pf_req (pf_req),
        .pf_rsp (pf_rsp),
        .snoop  (mem_req)
    );

    // Port 0 is the instruction side.
    pmem_arbiter pmem_arbiter_inst (
        .clk     (clk),
        .rst     (rst),
        .req0    (pf_req),
        .req1    (d_req),
        .rsp0    (pf_rsp),
        .rsp1    (d_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    line_memory #(
        .MEM_LINES   (MEM_LINES),
        .MEM_LATENCY (MEM_LATENCY)
    ) line_memory_inst (
        .clk (clk),
        .rst (rst),
        .req (mem_req),
        .rsp (mem_rsp)
    );

endmodule : mem_subsystem

// File: hw/pmem_arbiter.sv
`timescale 1ns/100ps

module pmem_arbiter (
    input  logic              clk,
    input  logic              rst,
    input  mem_pkg::mem_req_t req0,
    input  mem_pkg::mem_req_t req1,
    output mem_pkg::mem_rsp_t rsp0,
    output mem_pkg::mem_rsp_t rsp1,
    output mem_pkg::mem_req_t mem_req,
    input  mem_pkg::mem_rsp_t mem_rsp
);

    logic owned;        // A transaction is open.
    logic owner;
    logic prio;         // Port preferred when both ask.
    logic gap;
    logic want0;
    logic want1;
    logic pick;
    logic grant;
    logic active;
    logic sel;

    assign want0 = req0.read || req0.write;
    assign want1 = req1.read || req1.write;

    always_comb begin
        if (want0 && want1) begin
            pick = prio;
        end else begin
            pick = want1;
        end
    end

    // Nothing new is granted in the cycle right after a resp.
    assign grant  = !owned && !gap && (want0 || want1);
    assign active = owned || grant;
    assign sel    = owned ? owner : pick;

    // ********************
    // Mux and steering
    // ********************
    always_comb begin
        mem_req = '0;
        if (active) begin
            mem_req = sel ? req1 : req0;
        end
        rsp0.resp  = mem_rsp.resp && active && !sel;
        rsp0.rdata = mem_rsp.rdata;
        rsp1.resp  = mem_rsp.resp && active && sel;
        rsp1.rdata = mem_rsp.rdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            owned <= 1'b0;
            owner <= 1'b0;
            prio  <= 1'b0;
            gap   <= 1'b0;
        end else begin
            gap <= mem_rsp.resp;
            if (mem_rsp.resp) begin
                owned <= 1'b0;
                prio  <= !owner;           // Rotate to the other side.
            end else if (grant) begin
                owned <= 1'b1;
                owner <= pick;
            end
        end
    end

    // The granted request stays on the memory port until resp.
    assert property (@(posedge clk) disable iff (rst)
        (owned && !mem_rsp.resp) |=> $stable(mem_req))
        else $error("Memory request changed during an open transaction.");

endmodule : pmem_arbiter

// File: run.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f sim.f \
    --top-module mem_subsystem_tb \
    -Mdir obj_dir

./obj_dir/Vmem_subsystem_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression passed" sim.log; then
    exit 0
fi
exit 1

// File: sim.f
+incdir+include
hw/mem_pkg.sv
hw/line_prefetcher.sv
hw/pmem_arbiter.sv
hw/line_memory.sv
hw/mem_subsystem.sv
bench/mem_subsystem_tb.sv
